// File: Makefile
# Verilator build, run, lint and clean for the image rotator

TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := image_rotator_tb
RTL_TOP  := image_rotator_top
FLIST    := vlog.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

# the log decides pass or fail
run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/wb_host_tasks.svh
/* wishbone classic host tasks: single word write and read,
   with checks that each request gets exactly one ack */
`ifndef WB_HOST_TASKS_SVH
`define WB_HOST_TASKS_SVH

// cycles to wait for an ack before giving up
localparam int ACK_LIMIT = 8;

// one request, wait for its ack, release the bus on the ack cycle
task automatic single_access(input wb_adr_t adr, input logic we, input wb_dat_t dat,
		output wb_dat_t rdat);
	int waited;
	waited = 0;
	rdat = '0;
	@(negedge clk);
	// ack of the previous request must be gone by now
	if (wb_ack) begin
		$display("ack still high at %0t ns before the access to %h", $time, adr);
		bus_errs++;
	end
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we  = we;
	wb_adr = adr;
	wb_dat = dat;
	do begin
		@(negedge clk);
		waited++;
	end while (!wb_ack && waited < ACK_LIMIT);
	if (!wb_ack) begin
		$display("no ack at %0t ns for the access to %h", $time, adr);
		bus_errs++;
	end else if (waited != 1) begin
		$display("ack for %h came after %0d cycles instead of one", adr, waited);
		bus_errs++;
	end
	// read data is valid in the ack cycle
	rdat   = wb_rdat;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
endtask

task automatic write_word(input wb_adr_t adr, input wb_dat_t dat);
	wb_dat_t ignored;
	single_access(adr, 1'b1, dat, ignored);
endtask

task automatic read_word(input wb_adr_t adr, output wb_dat_t dat);
	single_access(adr, 1'b0, '0, dat);
endtask

`endif

// File: dv/image_rotator_tb.sv
/* testbench for the image rotator: case file reader, quarter-turn model,
   bus driven runs, image and status checks, watchdog */
`timescale 1ns/1ps

module image_rotator_tb
	import rot_pkg::*, img_pkg::*;
();
	localparam int N_POINTS      = 64;
	localparam int CORDIC_STAGES = 12;
	localparam int RAND_SEED     = 50948;
	localparam string CASE_FILE  = "dv/rotate_cases.txt";
	// status polls allowed per run
	localparam int POLL_LIMIT    = 4 * (IMG_SIZE + N_POINTS + CORDIC_STAGES);

	logic    clk;
	logic    reset;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat;
	logic    wb_ack;
	wb_dat_t wb_rdat;
	logic    done;

	int value_errs;
	int bus_errs;
	int run_errs;
	int limit_cycles;

	// points of the current case and the predicted image
	int   pt_x [$];
	int   pt_y [$];
	row_t exp_img [IMG_SIZE];

	image_rotator_top #(
		.N_POINTS(N_POINTS),
		.CORDIC_STAGES(CORDIC_STAGES)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat),
		.wb_ack_o(wb_ack),
		.wb_dat_o(wb_rdat),
		.done_o(done)
	);

	`include "wb_host_tasks.svh"

	// 40 ns period
	always #20 clk = ~clk;

	task automatic check_row(input string name, input row_t exp, input row_t got);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			value_errs++;
		end
	endtask

	task automatic check_status(input string name, input wb_dat_t exp, input wb_dat_t got);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			value_errs++;
		end
	endtask

	task automatic check_done(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
			value_errs++;
		end
	endtask

	function automatic angle_t quarter_angle(input int q);
		case (q)
			1:       return ANGLE_HALF_PI;
			2:       return ANGLE_PI;
			3:       return -ANGLE_HALF_PI;
			default: return '0;
		endcase
	endfunction

	function automatic wb_dat_t point_word(input int x, input int y);
		wb_dat_t w;
		w = '0;
		w[PT_X_LSB +: $bits(pix_t)] = pix_t'(x);
		w[PT_Y_LSB +: $bits(pix_t)] = pix_t'(y);
		return w;
	endfunction

	// quarter turns about the centre are exact in integers
	function automatic void predict_image(input int q, input int use_n);
		int dx;
		int dy;
		int t;
		for (int r = 0; r < IMG_SIZE; r++)
			exp_img[r] = '0;
		for (int i = 0; i < use_n; i++) begin
			dx = pt_x[i] - IMG_CENTRE;
			dy = pt_y[i] - IMG_CENTRE;
			// (dx,dy) goes to (-dy,dx) per turn
			for (int k = 0; k < q; k++) begin
				t  = dx;
				dx = -dy;
				dy = t;
			end
			dx = dx + IMG_CENTRE;
			dy = dy + IMG_CENTRE;
			if (dx >= 0 && dx < IMG_SIZE && dy >= 0 && dy < IMG_SIZE)
				exp_img[dy][dx] = 1'b1;
		end
	endfunction

	// case lines start with c
	function automatic int count_cases();
		int fd;
		int n;
		string line;
		n = 0;
		fd = $fopen(CASE_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line.getc(0) == "c")
					n++;
			end
			$fclose(fd);
		end
		return n;
	endfunction

	// load, start, poll for done, then compare every row
	task automatic run_case(input int q, input int use_n, input int hit);
		wb_dat_t rd;
		wb_dat_t ang_word;
		int n_use;
		int polls;
		n_use = (use_n == 0) ? pt_x.size() : use_n;
		for (int i = 0; i < pt_x.size(); i++)
			write_word(PT_BASE + wb_adr_t'(i), point_word(pt_x[i], pt_y[i]));
		ang_word = '0;
		ang_word[$bits(angle_t)-1:0] = quarter_angle(q);
		write_word(REG_ANGLE, ang_word);
		write_word(REG_COUNT, wb_dat_t'(n_use));
		write_word(REG_CTRL, 32'h1);
		read_word(REG_CTRL, rd);
		check_status("status after start", 32'h1, rd);
		check_done("done_o after start", 1'b0, done);
		if (hit != 0) begin
			// still in the clear phase so none of these may stick
			write_word(REG_ANGLE, 32'h0);
			write_word(REG_COUNT, 32'h1);
			write_word(PT_BASE, point_word(IMG_CENTRE, IMG_CENTRE));
			write_word(REG_CTRL, 32'h1);
		end
		polls = 0;
		do begin
			read_word(REG_CTRL, rd);
			polls++;
		end while (!rd[STAT_DONE_BIT] && polls < POLL_LIMIT);
		if (!rd[STAT_DONE_BIT]) begin
			$display("run with %0d quarter turns never reported done", q);
			run_errs++;
		end
		check_status("status after run", 32'h2, rd);
		check_done("done_o after run", 1'b1, done);
		predict_image(q, n_use);
		for (int r = 0; r < IMG_SIZE; r++) begin
			read_word(ROW_BASE + wb_adr_t'(r), rd);
			check_row($sformatf("row %0d", r), exp_img[r], row_t'(rd));
		end
	endtask

	initial begin
		int fd;
		int n;
		int q;
		int use_n;
		int hit;
		int pv [8];
		byte tag;
		string line;
		string rest;
		wb_dat_t rd;
		$timeformat(-9, 0, "", 0);
		void'($urandom(RAND_SEED));
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat = '0;
		value_errs = 0;
		bus_errs = 0;
		run_errs = 0;
		q = 0;
		use_n = 0;
		hit = 0;
		limit_cycles = (count_cases() + 1) * (IMG_SIZE + N_POINTS + CORDIC_STAGES + 200);
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// reset values
		check_done("done_o after reset", 1'b0, done);
		read_word(REG_CTRL, rd);
		check_status("status after reset", 32'h0, rd);
		read_word(REG_ANGLE, rd);
		check_status("angle after reset", 32'h0, rd);
		read_word(REG_COUNT, rd);
		check_status("count after reset", 32'h1, rd);

		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the case file %s", CASE_FILE);
			run_errs++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() == 0)
					continue;
				tag = line.getc(0);
				rest = line.substr(1, line.len() - 1);
				n = $sscanf(rest, "%d %d %d %d %d %d %d %d",
					pv[0], pv[1], pv[2], pv[3], pv[4], pv[5], pv[6], pv[7]);
				case (tag)
					"c": begin
						q = pv[0];
						use_n = pv[1];
						hit = pv[2];
						pt_x.delete();
						pt_y.delete();
					end
					"p": begin
						for (int k = 0; k + 1 < n; k += 2) begin
							pt_x.push_back(pv[k]);
							pt_y.push_back(pv[k+1]);
						end
					end
					"r": begin
						for (int k = 0; k < pv[0]; k++) begin
							pt_x.push_back(int'($urandom % IMG_SIZE));
							pt_y.push_back(int'($urandom % IMG_SIZE));
						end
					end
					"e": run_case(q, use_n, hit);
					default: ;
				endcase
			end
			$fclose(fd);
		end

		$display("errors: %0d value, %0d bus, %0d run", value_errs, bus_errs, run_errs);
		if (value_errs + bus_errs + run_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// scaled to the number of cases in the file
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not complete", limit_cycles);
		$display("errors: %0d value, %0d bus, %0d run", value_errs, bus_errs, run_errs);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: dv/rotate_cases.txt
# c q use hit: new case, q quarter turns, count register use (0 = all), hit 1 = writes while busy
# p x y ...: up to four explicit points   r n: n random points   e: run the case and check
c 0 0 0
p 3 5 16 16 31 0 0 31
p 10 21 25 2
e
c 1 0 0
p 5 0 20 0 10 20 31 31
p 16 16 0 16
e
c 2 3 0
p 1 2 20 7 9 30 0 8
p 28 28
e
c 3 0 1
p 7 25 30 12 0 0 12 31
e
c 0 0 0
r 24
e
c 1 0 0
r 32
e
c 2 20 0
r 32
e
c 3 0 0
r 40
e

// File: verilog/bitmap_plot.sv
/* 32 by 32 bitmap store: row clear, single pixel set, registered row read */
`timescale 1ns/1ps

module bitmap_plot
	import img_pkg::*;
(
	input  logic clk,
	input  logic clr_en_i,
	input  pix_t clr_row_i,
	input  logic plot_valid_i,
	input  pix_t plot_x_i,
	input  pix_t plot_y_i,
	input  pix_t rd_row_i,
	output row_t row_data_o
);
	// one word per image row
	row_t rows [IMG_SIZE];

	always_ff @(posedge clk) begin
		// clearing owns the store, no plots arrive then
		if (clr_en_i)
			rows[clr_row_i] <= '0;
		else if (plot_valid_i)
			rows[plot_y_i][plot_x_i] <= 1'b1;

		// host read, old contents if a write hits the same row
		row_data_o <= rows[rd_row_i];
	end

endmodule

// File: verilog/cordic_rotator.sv
/* pipelined point rotator: centre and gain scaling, pi pre-rotation,
   cordic iterations, then rounding back into image coordinates */
`timescale 1ns/1ps

module cordic_rotator
	import rot_pkg::*, img_pkg::*;
#(
	parameter int CORDIC_STAGES = 12
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   in_valid_i,
	input  pix_t   x_i,
	input  pix_t   y_i,
	input  angle_t angle_i,
	output logic   plot_valid_o,
	output pix_t   plot_x_o,
	output pix_t   plot_y_o,
	output logic   pipe_busy_o
);
	// centred inputs, -16..15
	logic signed [5:0] dx;
	logic signed [5:0] dy;

	// stage 0, centred and scaled by 1/K
	logic   s0_v;
	cord_t  s0_x;
	cord_t  s0_y;
	angle_t s0_z;

	// index 0 is after pre-rotation, index i+1 after iteration i
	logic [CORDIC_STAGES:0] cv;
	cord_t  cx [CORDIC_STAGES+1];
	cord_t  cy [CORDIC_STAGES+1];
	angle_t cz [CORDIC_STAGES+1];

	// rounding and re-centre
	logic signed [16:0] x_rnd;
	logic signed [16:0] y_rnd;
	logic [8:0] x_pos;
	logic [8:0] y_pos;
	logic in_range;

	assign dx = {1'b0, x_i} - 6'(IMG_CENTRE);
	assign dy = {1'b0, y_i} - 6'(IMG_CENTRE);

	// valid bits travel beside the data
	always_ff @(posedge clk) begin
		if (reset) begin
			s0_v         <= 1'b0;
			cv           <= '0;
			plot_valid_o <= 1'b0;
		end else begin
			s0_v         <= in_valid_i;
			cv           <= {cv[CORDIC_STAGES-1:0], s0_v};
			plot_valid_o <= cv[CORDIC_STAGES] & in_range;
		end
	end

	assign pipe_busy_o = s0_v | (|cv) | plot_valid_o;

	always_ff @(posedge clk) begin
		// integer times 1/K lands in 8 fraction bits
		s0_x <= cord_t'(dx) * CORDIC_GAIN_INV;
		s0_y <= cord_t'(dy) * CORDIC_GAIN_INV;
		s0_z <= angle_i;

		// fold angles past +-pi/2 by turning the vector half way round
		if (s0_z > ANGLE_HALF_PI) begin
			cx[0] <= -s0_x;
			cy[0] <= -s0_y;
			cz[0] <= s0_z - ANGLE_PI;
		end else if (s0_z < -ANGLE_HALF_PI) begin
			cx[0] <= -s0_x;
			cy[0] <= -s0_y;
			cz[0] <= s0_z + ANGLE_PI;
		end else begin
			cx[0] <= s0_x;
			cy[0] <= s0_y;
			cz[0] <= s0_z;
		end

		// one micro-rotation per stage, driving z toward zero
		for (int i = 0; i < CORDIC_STAGES; i++) begin
			if (cz[i] >= 0) begin
				cx[i+1] <= cx[i] - (cy[i] >>> i);
				cy[i+1] <= cy[i] + (cx[i] >>> i);
				cz[i+1] <= cz[i] - ATAN_TABLE[i];
			end else begin
				cx[i+1] <= cx[i] + (cy[i] >>> i);
				cy[i+1] <= cy[i] - (cx[i] >>> i);
				cz[i+1] <= cz[i] + ATAN_TABLE[i];
			end
		end

		plot_x_o <= x_pos[$bits(pix_t)-1:0];
		plot_y_o <= y_pos[$bits(pix_t)-1:0];
	end

	// add half an lsb, drop the fraction, move origin back to the corner
	assign x_rnd = 17'(cx[CORDIC_STAGES]) + 17'(1 << (CORD_FRAC - 1));
	assign y_rnd = 17'(cy[CORDIC_STAGES]) + 17'(1 << (CORD_FRAC - 1));
	assign x_pos = 9'(x_rnd >>> CORD_FRAC) + 9'(IMG_CENTRE);
	assign y_pos = 9'(y_rnd >>> CORD_FRAC) + 9'(IMG_CENTRE);

	// negative or >= 32 shows up in the upper bits
	assign in_range = (x_pos[8:$bits(pix_t)] == '0) && (y_pos[8:$bits(pix_t)] == '0);

endmodule

// File: verilog/image_rotator_top.sv
/* top level: bus control, point table, cordic pipeline and bitmap */
`timescale 1ns/1ps

module image_rotator_top
	import rot_pkg::*, img_pkg::*;
#(
	parameter int N_POINTS      = 64,
	parameter int CORDIC_STAGES = 12
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    wb_cyc_i,
	input  logic    wb_stb_i,
	input  logic    wb_we_i,
	input  wb_adr_t wb_adr_i,
	input  wb_dat_t wb_dat_i,
	output logic    wb_ack_o,
	output wb_dat_t wb_dat_o,
	output logic    done_o
);
	// point table
	logic                        pt_we;
	logic [$clog2(N_POINTS)-1:0] pt_widx;
	pix_t                        pt_wx;
	pix_t                        pt_wy;
	logic                        pt_re;
	logic [$clog2(N_POINTS)-1:0] pt_ridx;
	pix_t                        pt_rx;
	pix_t                        pt_ry;

	// rotator
	logic   in_valid;
	angle_t angle;
	logic   pipe_busy;
	logic   plot_valid;
	pix_t   plot_x;
	pix_t   plot_y;

	// bitmap
	logic clr_en;
	pix_t clr_row;
	pix_t rd_row;
	row_t row_data;

	rotate_ctrl #(
		.N_POINTS(N_POINTS)
	) ctrl_i (
		.clk(clk),
		.reset(reset),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.row_data_i(row_data),
		.pipe_busy_i(pipe_busy),
		.wb_ack_o(wb_ack_o),
		.wb_dat_o(wb_dat_o),
		.done_o(done_o),
		.pt_we_o(pt_we),
		.pt_widx_o(pt_widx),
		.pt_wx_o(pt_wx),
		.pt_wy_o(pt_wy),
		.pt_re_o(pt_re),
		.pt_ridx_o(pt_ridx),
		.in_valid_o(in_valid),
		.angle_o(angle),
		.clr_en_o(clr_en),
		.clr_row_o(clr_row),
		.rd_row_o(rd_row)
	);

	point_table #(
		.N_POINTS(N_POINTS)
	) table_i (
		.clk(clk),
		.we_i(pt_we),
		.widx_i(pt_widx),
		.wx_i(pt_wx),
		.wy_i(pt_wy),
		.re_i(pt_re),
		.ridx_i(pt_ridx),
		.rx_o(pt_rx),
		.ry_o(pt_ry)
	);

	cordic_rotator #(
		.CORDIC_STAGES(CORDIC_STAGES)
	) rot_i (
		.clk(clk),
		.reset(reset),
		.in_valid_i(in_valid),
		.x_i(pt_rx),
		.y_i(pt_ry),
		.angle_i(angle),
		.plot_valid_o(plot_valid),
		.plot_x_o(plot_x),
		.plot_y_o(plot_y),
		.pipe_busy_o(pipe_busy)
	);

	bitmap_plot bitmap_i (
		.clk(clk),
		.clr_en_i(clr_en),
		.clr_row_i(clr_row),
		.plot_valid_i(plot_valid),
		.plot_x_i(plot_x),
		.plot_y_i(plot_y),
		.rd_row_i(rd_row),
		.row_data_o(row_data)
	);

endmodule

// File: verilog/img_pkg.sv
/* image geometry, pixel and row types, wishbone widths and address map */
package img_pkg;

	// image is square, one row per bus word
	localparam int IMG_SIZE   = 32;
	localparam int IMG_CENTRE = 16;

	// pixel coordinate, 0..31
	typedef logic [4:0] pix_t;

	// one image row, bit x is pixel x
	typedef logic [31:0] row_t;

	// bus word address and data
	typedef logic [9:0]  wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// register map, word addresses
	localparam wb_adr_t REG_CTRL  = 10'h000;
	localparam wb_adr_t REG_ANGLE = 10'h001;
	localparam wb_adr_t REG_COUNT = 10'h002;
	localparam wb_adr_t PT_BASE   = 10'h100;
	localparam wb_adr_t ROW_BASE  = 10'h200;

	// ctrl write and status read bits
	localparam int CTRL_START_BIT = 0;
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_DONE_BIT  = 1;

	// point word fields
	localparam int PT_X_LSB = 0;
	localparam int PT_Y_LSB = 8;

endpackage

// File: verilog/point_table.sv
/* point list memory, host write port and registered read port */
`timescale 1ns/1ps

module point_table
	import img_pkg::*;
#(
	parameter int N_POINTS = 64
) (
	input  logic                        clk,
	input  logic                        we_i,
	input  logic [$clog2(N_POINTS)-1:0] widx_i,
	input  pix_t                        wx_i,
	input  pix_t                        wy_i,
	input  logic                        re_i,
	input  logic [$clog2(N_POINTS)-1:0] ridx_i,
	output pix_t                        rx_o,
	output pix_t                        ry_o
);
	// x and y kept side by side in one word
	logic [2*$bits(pix_t)-1:0] mem [N_POINTS];
	logic [2*$bits(pix_t)-1:0] rd_q;

	always_ff @(posedge clk) begin
		if (we_i)
			mem[widx_i] <= {wy_i, wx_i};
		// read holds its last value when idle
		if (re_i)
			rd_q <= mem[ridx_i];
	end

	assign rx_o = rd_q[$bits(pix_t)-1:0];
	assign ry_o = rd_q[2*$bits(pix_t)-1:$bits(pix_t)];

endmodule

// File: verilog/rot_pkg.sv
/* fixed-point types and constants for the cordic rotation:
   angle and working value formats, gain correction, arctangent table */
package rot_pkg;

	// angle in radians, 10 fraction bits
	typedef logic signed [12:0] angle_t;

	// cordic x/y working value, 8 fraction bits
	typedef logic signed [15:0] cord_t;

	// fraction bits of cord_t
	localparam int CORD_FRAC = 8;

	// pi and pi/2 scaled by 1024
	localparam angle_t ANGLE_PI      = 13'sd3217;
	localparam angle_t ANGLE_HALF_PI = 13'sd1608;

	// 1/K, about 0.60725 scaled by 256
	// applied once to the start vector
	localparam cord_t CORDIC_GAIN_INV = 16'sd155;

	// atan(2^-i) scaled by 1024, one per iteration
	localparam angle_t ATAN_TABLE [16] = '{
		13'sd804,
		13'sd475,
		13'sd251,
		13'sd127,
		13'sd64,
		13'sd32,
		13'sd16,
		13'sd8,
		13'sd4,
		13'sd2,
		13'sd1,
		13'sd0,
		13'sd0,
		13'sd0,
		13'sd0,
		13'sd0
	};

endpackage

// File: verilog/rotate_ctrl.sv
/* wishbone classic slave with register decode and point table writes,
   plus the run fsm that clears the bitmap and streams points */
`timescale 1ns/1ps

module rotate_ctrl
	import rot_pkg::*, img_pkg::*;
#(
	parameter int N_POINTS = 64
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  wb_adr_t                     wb_adr_i,
	input  wb_dat_t                     wb_dat_i,
	input  row_t                        row_data_i,
	input  logic                        pipe_busy_i,
	output logic                        wb_ack_o,
	output wb_dat_t                     wb_dat_o,
	output logic                        done_o,
	output logic                        pt_we_o,
	output logic [$clog2(N_POINTS)-1:0] pt_widx_o,
	output pix_t                        pt_wx_o,
	output pix_t                        pt_wy_o,
	output logic                        pt_re_o,
	output logic [$clog2(N_POINTS)-1:0] pt_ridx_o,
	output logic                        in_valid_o,
	output angle_t                      angle_o,
	output logic                        clr_en_o,
	output pix_t                        clr_row_o,
	output pix_t                        rd_row_o
);
	localparam int IDX_W = $clog2(N_POINTS);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_STREAM,
		ST_DRAIN,
		ST_FINISH
	} state_t;

	state_t         state;
	angle_t         angle_q;
	logic [IDX_W:0] count_q;
	logic [IDX_W-1:0] ridx_q;
	pix_t           row_q;
	logic           done_q;
	logic           busy;
	logic           acc;
	logic           wr_acc;
	logic           start;
	logic           row_sel;
	logic           row_sel_q;
	wb_dat_t        status;
	wb_dat_t        dat_q;

	// new request, not yet acked
	assign acc    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign wr_acc = acc & wb_we_i;
	assign busy   = (state != ST_IDLE);

	// rows live at ROW_BASE..ROW_BASE+31
	assign row_sel = (wb_adr_i[9:5] == ROW_BASE[9:5]);
	assign start   = wr_acc & (wb_adr_i == REG_CTRL) & wb_dat_i[CTRL_START_BIT] & ~busy;

	// point writes straight from the bus, dropped while running
	assign pt_we_o   = wr_acc & ~busy & (wb_adr_i[9:8] == PT_BASE[9:8]) &
		(wb_adr_i[7:0] < N_POINTS);
	assign pt_widx_o = wb_adr_i[IDX_W-1:0];
	assign pt_wx_o   = wb_dat_i[PT_X_LSB +: $bits(pix_t)];
	assign pt_wy_o   = wb_dat_i[PT_Y_LSB +: $bits(pix_t)];

	// datapath side
	assign pt_re_o   = (state == ST_STREAM);
	assign pt_ridx_o = ridx_q;
	assign clr_en_o  = (state == ST_CLEAR);
	assign clr_row_o = row_q;
	assign angle_o   = angle_q;
	assign done_o    = done_q;

	// bitmap row read lands in the ack cycle
	assign rd_row_o = wb_adr_i[4:0];
	assign wb_dat_o = row_sel_q ? row_data_i : dat_q;

	always_comb begin
		status = '0;
		status[STAT_BUSY_BIT] = busy;
		status[STAT_DONE_BIT] = done_q;
	end

	// one ack per request, then a gap
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack_o  <= 1'b0;
			row_sel_q <= 1'b0;
		end else begin
			wb_ack_o  <= acc;
			row_sel_q <= acc & ~wb_we_i & row_sel;
		end
	end

	// register read data
	always_ff @(posedge clk) begin
		if (acc) begin
			case (wb_adr_i)
				REG_CTRL:  dat_q <= status;
				REG_ANGLE: dat_q <= {{($bits(wb_dat_t) - $bits(angle_t)){1'b0}}, angle_q};
				REG_COUNT: dat_q <= wb_dat_t'(count_q);
				default:   dat_q <= '0;
			endcase
		end
	end

	// angle and count, frozen during a run
	always_ff @(posedge clk) begin
		if (reset) begin
			angle_q <= '0;
			count_q <= 1;
		end else if (wr_acc & ~busy) begin
			if (wb_adr_i == REG_ANGLE)
				angle_q <= wb_dat_i[$bits(angle_t)-1:0];
			if (wb_adr_i == REG_COUNT) begin
				// clamp to 1..table depth
				if (wb_dat_i == '0)
					count_q <= 1;
				else if (wb_dat_i > N_POINTS)
					count_q <= (IDX_W+1)'(N_POINTS);
				else
					count_q <= wb_dat_i[IDX_W:0];
			end
		end
	end

	// run sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_IDLE;
			row_q      <= '0;
			ridx_q     <= '0;
			done_q     <= 1'b0;
			in_valid_o <= 1'b0;
		end else begin
			// table read data shows up one cycle after the read
			in_valid_o <= pt_re_o;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state  <= ST_CLEAR;
						row_q  <= '0;
						done_q <= 1'b0;
					end
				end
				ST_CLEAR: begin
					// one row zeroed per cycle
					row_q <= row_q + 1'b1;
					if (row_q == pix_t'(IMG_SIZE - 1)) begin
						state  <= ST_STREAM;
						ridx_q <= '0;
					end
				end
				ST_STREAM: begin
					ridx_q <= ridx_q + 1'b1;
					if ({1'b0, ridx_q} + 1'b1 == count_q)
						state <= ST_DRAIN;
				end
				ST_DRAIN: begin
					// wait for last read and every stage to empty
					if (!in_valid_o && !pipe_busy_i)
						state <= ST_FINISH;
				end
				ST_FINISH: begin
					done_q <= 1'b1;
					state  <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: vlog.f
+incdir+dv
verilog/rot_pkg.sv
verilog/img_pkg.sv
verilog/point_table.sv
verilog/bitmap_plot.sv
verilog/cordic_rotator.sv
verilog/rotate_ctrl.sv
verilog/image_rotator_top.sv
dv/image_rotator_tb.sv
